// File: source/decode_pkg.sv
package decode_pkg;

	localparam int DATA_W = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_IDX_W = 5;
	localparam int SHAMT_W = 5;

	typedef enum logic [5:0] {
		OPC_RTYPE  = 6'b000000,
		OPC_REGIMM = 6'b000001,
		OPC_J      = 6'b000010,
		OPC_JAL    = 6'b000011,
		OPC_BEQ    = 6'b000100,
		OPC_BNE    = 6'b000101,
		OPC_BLEZ   = 6'b000110,
		OPC_BGTZ   = 6'b000111,
		OPC_ADDI   = 6'b001000,
		OPC_ADDIU  = 6'b001001,
		OPC_SLTI   = 6'b001010,
		OPC_SLTIU  = 6'b001011,
		OPC_ORI    = 6'b001101,
		OPC_XORI   = 6'b001110,
		OPC_LUI    = 6'b001111,
		OPC_MUL    = 6'b011100, // SPECIAL2, MUL only
		OPC_LB     = 6'b100000,
		OPC_LW     = 6'b100011,
		OPC_LBU    = 6'b100100,
		OPC_SB     = 6'b101000,
		OPC_SW     = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL   = 6'b000000,
		FN_SRL   = 6'b000010,
		FN_SRA   = 6'b000011,
		FN_SLLV  = 6'b000100,
		FN_SRLV  = 6'b000110,
		FN_SRAV  = 6'b000111,
		FN_JR    = 6'b001000,
		FN_JALR  = 6'b001001,
		FN_MFHI  = 6'b010000,
		FN_MFLO  = 6'b010010,
		FN_MULT  = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_DIV   = 6'b011010,
		FN_DIVU  = 6'b011011,
		FN_ADD   = 6'b100000,
		FN_ADDU  = 6'b100001,
		FN_SUB   = 6'b100010,
		FN_SUBU  = 6'b100011,
		FN_AND   = 6'b100100,
		FN_OR    = 6'b100101,
		FN_NOR   = 6'b100111,
		FN_SLT   = 6'b101010,
		FN_SLTU  = 6'b101011
	} funct_e;

	// MUL shares the SRL function code, told apart by its opcode
	localparam funct_e MUL_FUNCT = FN_SRL;

	typedef enum logic [4:0] {
		RI_BLTZ = 5'b00000,
		RI_BGEZ = 5'b00001
	} regimm_e;

	typedef enum logic [2:0] {
		NOP_TYPE    = 3'd0,
		R_TYPE      = 3'd1,
		I_TYPE      = 3'd2,
		REGIMM_TYPE = 3'd3,
		J_TYPE      = 3'd4,
		BAD_TYPE    = 3'd5
	} insn_class_e;

	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MFHI, OP_MFLO,
		OP_SLT, OP_SLTU,
		OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
		OP_AND, OP_OR, OP_NOR,
		OP_JALR, OP_JR,
		OP_MUL,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI,
		OP_LW, OP_SW, OP_LB, OP_LBU, OP_SB, OP_LUI,
		OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ,
		OP_BLTZ, OP_BGEZ,
		OP_J, OP_JAL,
		OP_ILLEGAL = 6'h3f
	} alu_op_e;

	typedef struct packed {
		alu_op_e                alu_op;
		insn_class_e            insn_class;
		logic [REG_IDX_W-1:0]   rs;
		logic [REG_IDX_W-1:0]   rt;
		logic [REG_IDX_W-1:0]   dest;
		logic [SHAMT_W-1:0]     shamt;
		logic [DATA_W-1:0]      imm; // Extended immediate or jump target
		logic [DATA_W-1:0]      pc;
	} decoded_insn_t;

	typedef struct packed {
		logic                   strobe;
		logic [REG_IDX_W-1:0]   idx;
		logic [DATA_W-1:0]      data;
	} rf_write_t;

endpackage

// File: source/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
	input  logic [decode_pkg::DATA_W-1:0] insn,
	input  logic [decode_pkg::DATA_W-1:0] pc,
	output decode_pkg::decoded_insn_t     decoded
);

	import decode_pkg::*;

	opcode_e opcode;
	funct_e funct;
	regimm_e regimm_sel;
	logic [REG_IDX_W-1:0] f_rs;
	logic [REG_IDX_W-1:0] f_rt;
	logic [REG_IDX_W-1:0] f_rd;
	logic [SHAMT_W-1:0] f_shamt;
	logic [DATA_W-1:0] imm_sx;
	logic [DATA_W-1:0] imm_jt;

	alu_op_e op;
	insn_class_e cls;

	assign opcode = opcode_e'(insn[31:26]);
	assign funct = funct_e'(insn[5:0]);
	assign regimm_sel = regimm_e'(insn[20:16]);
	assign f_rs = insn[25:21];
	assign f_rt = insn[20:16];
	assign f_rd = insn[15:11];
	assign f_shamt = insn[10:6];
	assign imm_sx = {{(DATA_W-16){insn[15]}}, insn[15:0]};
	assign imm_jt = {{(DATA_W-26){1'b0}}, insn[25:0]};

	// Classification and operation select
	always_comb begin
		op = OP_ILLEGAL;
		cls = BAD_TYPE;
		if (insn == '0) begin
			op = OP_NOP;
			cls = NOP_TYPE;
		end else begin
			case (opcode)
				OPC_RTYPE: begin
					cls = R_TYPE;
					case (funct)
						FN_ADD: op = OP_ADD;
						FN_ADDU: op = OP_ADDU;
						FN_SUB: op = OP_SUB;
						FN_SUBU: op = OP_SUBU;
						FN_MULT: op = OP_MULT;
						FN_MULTU: op = OP_MULTU;
						FN_DIV: op = OP_DIV;
						FN_DIVU: op = OP_DIVU;
						FN_MFHI: op = OP_MFHI;
						FN_MFLO: op = OP_MFLO;
						FN_SLT: op = OP_SLT;
						FN_SLTU: op = OP_SLTU;
						FN_SLL: op = OP_SLL;
						FN_SLLV: op = OP_SLLV;
						FN_SRL: op = OP_SRL;
						FN_SRLV: op = OP_SRLV;
						FN_SRA: op = OP_SRA;
						FN_SRAV: op = OP_SRAV;
						FN_AND: op = OP_AND;
						FN_OR: op = OP_OR;
						FN_NOR: op = OP_NOR;
						FN_JALR: op = OP_JALR;
						FN_JR: op = OP_JR;
						default: cls = BAD_TYPE;
					endcase
				end
				OPC_MUL: begin
					if (funct == MUL_FUNCT) begin
						op = OP_MUL;
						cls = R_TYPE;
					end
				end
				OPC_REGIMM: begin
					cls = REGIMM_TYPE;
					case (regimm_sel)
						RI_BLTZ: op = OP_BLTZ;
						RI_BGEZ: op = OP_BGEZ;
						default: cls = BAD_TYPE;
					endcase
				end
				OPC_J: begin
					op = OP_J;
					cls = J_TYPE;
				end
				OPC_JAL: begin
					op = OP_JAL;
					cls = J_TYPE;
				end
				default: begin
					cls = I_TYPE;
					case (opcode)
						OPC_ADDI: op = OP_ADDI;
						OPC_ADDIU: op = OP_ADDIU;
						OPC_SLTI: op = OP_SLTI;
						OPC_SLTIU: op = OP_SLTIU;
						OPC_ORI: op = OP_ORI;
						OPC_XORI: op = OP_XORI;
						OPC_LW: op = OP_LW;
						OPC_SW: op = OP_SW;
						OPC_LB: op = OP_LB;
						OPC_LBU: op = OP_LBU;
						OPC_SB: op = OP_SB;
						OPC_LUI: op = OP_LUI;
						OPC_BEQ: op = OP_BEQ;
						OPC_BNE: op = OP_BNE;
						OPC_BGTZ: op = OP_BGTZ;
						OPC_BLEZ: op = OP_BLEZ;
						default: cls = BAD_TYPE;
					endcase
				end
			endcase
		end
	end

	// Field shaping, class defaults first, then per-operation exceptions
	always_comb begin
		decoded = '0;
		decoded.alu_op = op;
		decoded.insn_class = cls;
		decoded.pc = pc;
		case (cls)
			R_TYPE: begin
				decoded.rs = f_rs;
				decoded.rt = f_rt;
				decoded.dest = f_rd;
			end
			I_TYPE, REGIMM_TYPE: begin
				decoded.rs = f_rs;
				decoded.rt = f_rt;
				decoded.imm = imm_sx;
			end
			J_TYPE: decoded.imm = imm_jt;
			default: ; // NOP and illegal keep zero fields
		endcase
		case (op)
			OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: decoded.dest = '0; // Result goes to HI/LO
			OP_JR: begin
				decoded.rt = '0;
				decoded.dest = '0;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				decoded.rs = '0;
				decoded.shamt = f_shamt;
			end
			OP_MFHI, OP_MFLO: begin
				decoded.rs = '0;
				decoded.rt = '0;
			end
			OP_LUI: begin
				decoded.rs = '0;
				decoded.dest = f_rt;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ORI, OP_XORI,
			OP_LW, OP_LB, OP_LBU: decoded.dest = f_rt;
			OP_JAL: decoded.dest = REG_IDX_W'(31); // Link register
			default: ;
		endcase
	end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file #(
	parameter int REG_COUNT_P = decode_pkg::REG_COUNT,
	parameter int DATA_W_P = decode_pkg::DATA_W
) (
	input  logic                             clock,
	input  logic                             arst_n,
	input  decode_pkg::rf_write_t            wb,
	input  logic [decode_pkg::REG_IDX_W-1:0] rs_idx,
	input  logic [decode_pkg::REG_IDX_W-1:0] rt_idx,
	output logic [DATA_W_P-1:0]              rs_data,
	output logic [DATA_W_P-1:0]              rt_data
);

	logic [DATA_W_P-1:0] regs [REG_COUNT_P];
	logic wr_en;
	logic rs_zero;
	logic rt_zero;

	// Register 0 and out-of-range indices read zero and ignore writes
	assign wr_en = wb.strobe && (wb.idx != '0) && (int'(wb.idx) < REG_COUNT_P);
	assign rs_zero = (rs_idx == '0) || (int'(rs_idx) >= REG_COUNT_P);
	assign rt_zero = (rt_idx == '0) || (int'(rt_idx) >= REG_COUNT_P);

	always_ff @(posedge clock) begin
		if (wr_en) begin
			regs[wb.idx] <= DATA_W_P'(wb.data);
		end
	end

	// Combinational reads show a write right after its edge
	assign rs_data = rs_zero ? '0 : regs[rs_idx];
	assign rt_data = rt_zero ? '0 : regs[rt_idx];

	wb_fields_known: assert property (
		@(posedge clock) disable iff (!arst_n)
		wb.strobe |-> !$isunknown({wb.idx, wb.data})
	) else $error("writeback strobe with unknown index or data");

endmodule

// File: source/decode_register.sv
`timescale 1ns/1ps

module decode_register (
	input  logic                      clock,
	input  logic                      arst_n,
	input  logic                      insn_valid,
	input  decode_pkg::decoded_insn_t next_decoded,
	output logic                      out_valid,
	output decode_pkg::decoded_insn_t decoded
);

	import decode_pkg::*;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= insn_valid; // One-cycle strobe
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			decoded <= '0;
		end else if (insn_valid) begin
			decoded <= next_decoded; // Held until next strobe
		end
	end

	// An illegal word must never name a register for writeback
	illegal_has_no_dest: assert property (
		@(posedge clock) disable iff (!arst_n)
		out_valid |-> !(decoded.alu_op == OP_ILLEGAL && decoded.dest != '0)
	) else $error("illegal instruction carries destination %0d", decoded.dest);

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
	parameter int REG_COUNT_P = decode_pkg::REG_COUNT,
	parameter int DATA_W_P = decode_pkg::DATA_W
) (
	input  logic                          clock,
	input  logic                          arst_n,
	input  logic                          insn_valid,
	input  logic [decode_pkg::DATA_W-1:0] insn,
	input  logic [decode_pkg::DATA_W-1:0] pc,
	input  decode_pkg::rf_write_t         wb,
	output logic                          out_valid,
	output decode_pkg::decoded_insn_t     decoded,
	output logic [DATA_W_P-1:0]           rs_data,
	output logic [DATA_W_P-1:0]           rt_data
);

	import decode_pkg::*;

	decoded_insn_t next_decoded;

	insn_decoder insn_decoder_i (
		.insn    (insn),
		.pc      (pc),
		.decoded (next_decoded)
	);

	decode_register decode_register_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.insn_valid   (insn_valid),
		.next_decoded (next_decoded),
		.out_valid    (out_valid),
		.decoded      (decoded)
	);

	// Read at the registered indices so data lines up with the record
	register_file #(
		.REG_COUNT_P (REG_COUNT_P),
		.DATA_W_P    (DATA_W_P)
	) register_file_i (
		.clock   (clock),
		.arst_n  (arst_n),
		.wb      (wb),
		.rs_idx  (decoded.rs),
		.rt_idx  (decoded.rt),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

endmodule

// File: testbench/decode_checks.svh
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// One line per record, enum fields by name
function automatic string decoded_text(input decode_pkg::decoded_insn_t d);
	decode_pkg::alu_op_e op;
	decode_pkg::insn_class_e cls;
	op = d.alu_op;
	cls = d.insn_class;
	return $sformatf("{op %0s cls %0s rs %0d rt %0d dest %0d shamt %0d imm %h pc %h}",
		op.name(), cls.name(), d.rs, d.rt, d.dest, d.shamt, d.imm, d.pc);
endfunction

task automatic check_decoded(
	input string                     test_name,
	input decode_pkg::decoded_insn_t expected,
	input decode_pkg::decoded_insn_t actual
);
	if (actual !== expected) begin
		fail_run($sformatf("[ERROR] %s: decoded expected %s, actual %s",
			test_name, decoded_text(expected), decoded_text(actual)));
	end
endtask

task automatic check_data(
	input string               test_name,
	input string               port_name,
	input logic [DATA_W_P-1:0] expected,
	input logic [DATA_W_P-1:0] actual
);
	if (actual !== expected) begin
		fail_run($sformatf("[ERROR] %s: %s expected %h, actual %h",
			test_name, port_name, expected, actual));
	end
endtask

`endif

// File: testbench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

	import decode_pkg::*;

	localparam int DATA_W_P = DATA_W;
	localparam int REG_COUNT_P = REG_COUNT;
	localparam int VALID_TIMEOUT = 10;
	localparam string STIM_FILE = "testbench/decode_stimulus.txt";

	logic clock;
	logic arst_n;
	logic insn_valid;
	logic [DATA_W-1:0] insn;
	logic [DATA_W-1:0] pc;
	rf_write_t wb;
	logic out_valid;
	decoded_insn_t decoded;
	logic [DATA_W_P-1:0] rs_data;
	logic [DATA_W_P-1:0] rt_data;
	int insn_count;

	decode_stage #(
		.REG_COUNT_P (REG_COUNT_P),
		.DATA_W_P    (DATA_W_P)
	) decode_stage_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.pc         (pc),
		.wb         (wb),
		.out_valid  (out_valid),
		.decoded    (decoded),
		.rs_data    (rs_data),
		.rt_data    (rt_data)
	);

	always #20 clock = ~clock; // 40 ns period

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	`include "decode_checks.svh"

	task automatic apply_writeback(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
		wb.strobe = 1'b1;
		wb.idx = idx;
		wb.data = data;
		@(negedge clock);
		wb.strobe = 1'b0;
	endtask

	// Strobe one word, optionally with a writeback on the same edge
	task automatic run_insn(
		input string               name,
		input logic [DATA_W-1:0]   word,
		input logic [DATA_W-1:0]   pc_value,
		input decoded_insn_t       expected,
		input logic [DATA_W_P-1:0] exp_rs,
		input logic [DATA_W_P-1:0] exp_rt,
		input rf_write_t           same_edge_wb,
		input int                  idle
	);
		int waited;
		insn_valid = 1'b1;
		insn = word;
		pc = pc_value;
		wb = same_edge_wb;
		@(negedge clock);
		insn_valid = 1'b0;
		wb.strobe = 1'b0;
		waited = 1;
		while (!out_valid) begin
			if (waited >= VALID_TIMEOUT) begin
				fail_run($sformatf("%s: out_valid never rose within %0d cycles of the strobe",
					name, VALID_TIMEOUT));
			end
			@(negedge clock);
			waited++;
		end
		if (waited != 1) begin
			fail_run($sformatf("%s: out_valid came %0d cycles after the strobe, not 1",
				name, waited));
		end
		check_decoded(name, expected, decoded);
		check_data(name, "rs_data", exp_rs, rs_data);
		check_data(name, "rt_data", exp_rt, rt_data);
		insn_count++;
		repeat (idle) begin
			@(negedge clock);
			if (out_valid) begin
				fail_run($sformatf("%s: out_valid stayed high after its one cycle", name));
			end
		end
	endtask

	initial begin
		int fd;
		int n;
		int idle;
		string line;
		string kind;
		string name;
		logic [31:0] idx_v, data_v, word_v, pc_v, op_v, cls_v;
		logic [31:0] rs_v, rt_v, dest_v, shamt_v, imm_v, rsd_v, rtd_v;
		decoded_insn_t exp_rec;
		rf_write_t staged;
		clock = 1'b0;
		arst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		wb = '0;
		staged = '0;
		insn_count = 0;
		void'($urandom(26));
		repeat (3) @(negedge clock);
		arst_n = 1'b1;
		repeat (3) begin // Idle after reset
			@(negedge clock);
			if (out_valid) begin
				fail_run("out_valid went high after reset with no instruction strobed");
			end
			check_decoded("after_reset", '0, decoded);
		end
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			fail_run("could not open the stimulus file testbench/decode_stimulus.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") continue;
			n = $sscanf(line, "%s", kind);
			if (kind == "W" || kind == "S") begin
				n = $sscanf(line, "%s %h %h", kind, idx_v, data_v);
				if (n != 3) fail_run($sformatf("malformed writeback line: %s", line));
				if (kind == "W") begin
					apply_writeback(idx_v[REG_IDX_W-1:0], data_v);
				end else begin
					staged.strobe = 1'b1; // Goes out with the next instruction
					staged.idx = idx_v[REG_IDX_W-1:0];
					staged.data = data_v;
				end
			end else if (kind == "I" || kind == "B") begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h", kind, name,
					word_v, pc_v, op_v, cls_v, rs_v, rt_v, dest_v, shamt_v, imm_v, rsd_v, rtd_v);
				if (n != 13) fail_run($sformatf("malformed instruction line: %s", line));
				exp_rec.alu_op = alu_op_e'(op_v[5:0]);
				exp_rec.insn_class = insn_class_e'(cls_v[2:0]);
				exp_rec.rs = rs_v[REG_IDX_W-1:0];
				exp_rec.rt = rt_v[REG_IDX_W-1:0];
				exp_rec.dest = dest_v[REG_IDX_W-1:0];
				exp_rec.shamt = shamt_v[SHAMT_W-1:0];
				exp_rec.imm = imm_v;
				exp_rec.pc = pc_v;
				idle = (kind == "B") ? 0 : int'($urandom_range(3, 0));
				run_insn(name, word_v, pc_v, exp_rec, rsd_v, rtd_v, staged, idle);
				staged = '0;
			end else begin
				fail_run($sformatf("unknown line kind in stimulus file: %s", line));
			end
		end
		$fclose(fd);
		if (insn_count == 0) begin
			fail_run("the stimulus file held no instructions");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

// File: testbench/decode_stimulus.txt
# W idx data = writeback alone; S idx data = writeback on the next instruction's edge
# I|B name insn pc alu_op class rs rt dest shamt imm rs_data rt_data (hex, B = no idle after)
W 01 11111111
W 02 22222222
W 03 80000003
W 04 0000abcd
W 05 55555555
W 06 66666666
W 07 77777777
W 08 fedcba98
W 1f 0badf00d
I add 00224820 00400000 01 1 01 02 09 00 00000000 11111111 22222222
I subu 00645023 00400004 04 1 03 04 0a 00 00000000 80000003 0000abcd
I mult 00a60018 00400008 05 1 05 06 00 00 00000000 55555555 66666666
I divu_rd_ignored 00e8181b 0040000c 08 1 07 08 00 00 00000000 77777777 fedcba98
I sll_rs_cleared 00a259c0 00400010 0d 1 00 02 0b 07 00000000 00000000 22222222
I sra 000867c3 00400014 11 1 00 08 0c 1f 00000000 00000000 fedcba98
I srav 00836807 00400018 12 1 04 03 0d 00 00000000 0000abcd 80000003
I mfhi 00227010 0040001c 09 1 00 00 0e 00 00000000 00000000 00000000
I jr_rt_cleared 03e20008 00400020 17 1 1f 00 00 00 00000000 0badf00d 00000000
I jalr 00c0f809 00400024 16 1 06 00 1f 00 00000000 66666666 00000000
I nor 00257827 00400028 15 1 01 05 0f 00 00000000 11111111 55555555
I sltu 0061882b 0040002c 0c 1 03 01 11 00 00000000 80000003 11111111
I mul 70478002 00400030 18 1 02 07 10 00 00000000 22222222 77777777
I addi_neg 2025fffc 00400100 19 2 01 05 05 00 fffffffc 11111111 55555555
I addiu_pos 24461234 00400104 1a 2 02 06 06 00 00001234 22222222 66666666
I lw_neg 8c878000 00400108 1f 2 04 07 07 00 ffff8000 0000abcd 77777777
I lbu_pos 91037fff 0040010c 22 2 08 03 03 00 00007fff fedcba98 80000003
I sw ac22fff0 00400110 20 2 01 02 00 00 fffffff0 11111111 22222222
I sb a0c50010 00400114 23 2 06 05 00 00 00000010 66666666 55555555
I lui 3c68abcd 00400118 24 2 00 08 08 00 ffffabcd 00000000 fedcba98
I beq 1022fffe 0040011c 25 2 01 02 00 00 fffffffe 11111111 22222222
I bgtz 1c600040 00400120 27 2 03 00 00 00 00000040 80000003 00000000
I xori 38e48001 00400124 1e 2 07 04 04 00 ffff8001 77777777 0000abcd
I bltz 0460fff8 00400128 29 3 03 00 00 00 fffffff8 80000003 00000000
I bgez 04810100 0040012c 2a 3 04 01 00 00 00000100 0000abcd 11111111
I j 0bffffff 00400130 2b 4 00 00 00 00 03ffffff 00000000 00000000
I jal 0c123456 00400134 2c 4 00 00 1f 00 00123456 00000000 00000000
I nop 00000000 00400138 00 0 00 00 00 00 00000000 00000000 00000000
I bad_opcode fc221234 0040013c 3f 5 00 00 00 00 00000000 00000000 00000000
I bad_funct 00224801 00400140 3f 5 00 00 00 00 00000000 00000000 00000000
I bad_regimm 04420010 00400144 3f 5 00 00 00 00 00000000 00000000 00000000
I bad_special2 70478000 00400148 3f 5 00 00 00 00 00000000 00000000 00000000
W 00 deadbeef
I reg0_after_write 00000820 0040014c 01 1 00 00 01 00 00000000 00000000 00000000
S 05 a5a5a5a5
B same_edge_or 00a11025 00400200 14 1 05 01 02 00 00000000 a5a5a5a5 11111111
S 06 c3c3c3c3
B b2b_sub 00c51822 00400204 03 1 06 05 03 00 00000000 c3c3c3c3 a5a5a5a5
B b2b_and 00222024 00400208 13 1 01 02 04 00 00000000 11111111 22222222
I b2b_last 00a11025 0040020c 14 1 05 01 02 00 00000000 a5a5a5a5 11111111

// File: project.f
+incdir+testbench
source/decode_pkg.sv
source/insn_decoder.sv
source/register_file.sv
source/decode_register.sv
source/decode_stage.sv
testbench/decode_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	-f project.f --top-module decode_stage_tb -o decode_stage_tb \
	&& ./obj_dir/decode_stage_tb \
	|| { echo "decode stage simulation did not complete cleanly"; exit 1; }
